// File: logic/rename_pkg.sv
// register renaming shared definitions

package rename_pkg;

	// logical register file
	localparam int NUM_LOGIC  = 32;
	localparam int LOGIC_W    = 5;  // index into the logical file

	// physical tag space
	localparam int NUM_TAGS   = 64;
	localparam int TAG_W      = 6;

	// reorder buffer sizing
	localparam int ROB_DEPTH  = 32;
	localparam int ROB_PTR_W  = 6;  // index bits plus one wrap bit

	// free list holds what is left after the architectural 32 are mapped
	localparam int FREE_DEPTH = 32;

	// one dispatch request, destination plus two sources
	typedef struct packed {
		logic [LOGIC_W-1:0] logic_dest;
		logic [LOGIC_W-1:0] src1;
		logic [LOGIC_W-1:0] src2;
	} rename_req_t;

	// renamed view of the request
	typedef struct packed {
		logic [TAG_W-1:0] src1_tag;
		logic [TAG_W-1:0] src2_tag;
		logic [TAG_W-1:0] dest_tag;     // fresh tag from the free list
		logic [TAG_W-1:0] old_dest_tag; // mapping the destination had before
	} rename_rsp_t;

	// head entry as it leaves the machine
	typedef struct packed {
		logic [LOGIC_W-1:0] logic_dest;
		logic [TAG_W-1:0]   dest_tag;
		logic [TAG_W-1:0]   old_dest_tag; // goes back to the free list
	} retire_info_t;

endpackage

// File: logic/free_list.sv
// physical tag free list

`timescale 1ns/10ps

module free_list (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         dispatch_i, // pop the head tag
	input  logic                         push_i,     // retired old tag comes back
	input  logic [rename_pkg::TAG_W-1:0] push_tag_i,
	output logic [rename_pkg::TAG_W-1:0] free_tag_o  // next tag to hand out
);

	// pointers carry one wrap bit above the index
	typedef logic [$clog2(rename_pkg::FREE_DEPTH):0]   fl_ptr_t;
	typedef logic [$clog2(rename_pkg::FREE_DEPTH)-1:0] fl_idx_t;

	logic [rename_pkg::TAG_W-1:0] tags_q [rename_pkg::FREE_DEPTH]; // circular storage

	fl_ptr_t head_q; // oldest free tag
	fl_ptr_t tail_q; // next slot to fill
	fl_idx_t head_idx;
	fl_idx_t tail_idx;

	assign head_idx = head_q[$clog2(rename_pkg::FREE_DEPTH)-1:0];
	assign tail_idx = tail_q[$clog2(rename_pkg::FREE_DEPTH)-1:0];

	// head tag is visible without waiting for the edge
	assign free_tag_o = tags_q[head_idx];

	// head pointer, one pop per dispatch
	always_ff @(posedge clock) begin
		if (reset) begin
			head_q <= '0;
		end else if (dispatch_i) begin
			head_q <= head_q + 1'b1;
		end
	end

	// tail pointer starts one lap ahead so the queue reads as full
	always_ff @(posedge clock) begin
		if (reset) begin
			tail_q <= fl_ptr_t'(rename_pkg::FREE_DEPTH);
		end else if (push_i) begin
			tail_q <= tail_q + 1'b1;
		end
	end

	// storage is preloaded with the tags the map does not own
	// a push never lands on the head slot since the queue is not full when it happens
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < rename_pkg::FREE_DEPTH; i++) begin
				// tags 32 upward, in order
				tags_q[i] <= rename_pkg::TAG_W'(rename_pkg::NUM_TAGS - rename_pkg::FREE_DEPTH + i);
			end
		end else if (push_i) begin
			tags_q[tail_idx] <= push_tag_i; // append behind everything already free
		end
	end

	// a pop and a push in one cycle touch different slots and pointers
	// the queue cannot run dry because the rob fills up first
	// occupancy is tail minus head

endmodule

// File: logic/map_table.sv
// speculative register map table

`timescale 1ns/10ps

module map_table (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         dispatch_i, // write the new mapping
	input  rename_pkg::rename_req_t      req_i,
	input  logic [rename_pkg::TAG_W-1:0] new_tag_i,  // tag from the free list
	output logic [rename_pkg::TAG_W-1:0] src1_tag_o,
	output logic [rename_pkg::TAG_W-1:0] src2_tag_o,
	output logic [rename_pkg::TAG_W-1:0] old_tag_o   // destination's current tag
);

	// one tag per logical register
	logic [rename_pkg::TAG_W-1:0] map_q [rename_pkg::NUM_LOGIC];

	// logical indices of the request
	logic [rename_pkg::LOGIC_W-1:0] dest_idx;
	logic [rename_pkg::LOGIC_W-1:0] src1_idx;
	logic [rename_pkg::LOGIC_W-1:0] src2_idx;

	assign dest_idx = req_i.logic_dest;
	assign src1_idx = req_i.src1;
	assign src2_idx = req_i.src2;

	// three read ports, all combinational
	// they see the map before this cycle's write, so a source that
	// names the destination still gets the older tag
	assign src1_tag_o = map_q[src1_idx];
	assign src2_tag_o = map_q[src2_idx];
	assign old_tag_o  = map_q[dest_idx]; // the tag this dispatch displaces

	// single write port
	always_ff @(posedge clock) begin
		if (reset) begin
			// identity map, register r lives in tag r
			for (int r = 0; r < rename_pkg::NUM_LOGIC; r++) begin
				map_q[r] <= rename_pkg::TAG_W'(r);
			end
		end else if (dispatch_i) begin
			map_q[dest_idx] <= new_tag_i; // visible to reads from the next cycle
		end
	end

	// the displaced tag is not freed here
	// it rides in the rob until the instruction retires
	// there is no checkpoint, so a flush would need an architectural copy

endmodule

// File: logic/rob.sv
// reorder buffer with in-order retirement

`timescale 1ns/10ps

module rob (
	input  logic                         clock,
	input  logic                         reset,

	// dispatch side
	input  logic                         dispatch_i,
	input  rename_pkg::rename_req_t      req_i,
	input  logic [rename_pkg::TAG_W-1:0] new_tag_i,  // from free list
	input  logic [rename_pkg::TAG_W-1:0] src1_tag_i, // from map table
	input  logic [rename_pkg::TAG_W-1:0] src2_tag_i,
	input  logic [rename_pkg::TAG_W-1:0] old_tag_i,

	// completion
	input  logic                         ex_done_i,
	input  logic [rename_pkg::TAG_W-1:0] ex_tag_i,

	// retirement
	input  logic                         retire_i,

	output rename_pkg::rename_rsp_t      rsp_o,
	output logic                         dispatch_rdy_o, // room for one more
	output logic                         retire_rdy_o,   // head is done
	output rename_pkg::retire_info_t     retire_o,
	output logic                         free_o,         // old tag back to free list
	output logic [rename_pkg::TAG_W-1:0] free_tag_o
);

	// what each slot remembers about its instruction
	typedef struct packed {
		logic [rename_pkg::LOGIC_W-1:0] logic_dest;
		logic [rename_pkg::TAG_W-1:0]   dest_tag;
		logic [rename_pkg::TAG_W-1:0]   old_dest_tag;
	} rob_entry_t;

	typedef logic [rename_pkg::ROB_PTR_W-1:0] rob_ptr_t; // wrap bit on top
	typedef logic [rename_pkg::ROB_PTR_W-2:0] rob_idx_t;

	rob_entry_t                       entry_q [rename_pkg::ROB_DEPTH]; // payload
	logic [rename_pkg::ROB_DEPTH-1:0] valid_q; // slot is occupied
	logic [rename_pkg::ROB_DEPTH-1:0] done_q;  // execution finished

	rob_ptr_t head_q; // oldest instruction
	rob_ptr_t tail_q; // next free slot
	rob_idx_t head_idx;
	rob_idx_t tail_idx;

	rob_entry_t new_entry;
	rob_entry_t head_entry;
	logic       full;
	logic       empty;

	assign head_idx = head_q[rename_pkg::ROB_PTR_W-2:0];
	assign tail_idx = tail_q[rename_pkg::ROB_PTR_W-2:0];

	// same index with opposite wrap bits means a full lap
	assign full  = (head_q[rename_pkg::ROB_PTR_W-1] != tail_q[rename_pkg::ROB_PTR_W-1])
		&& (head_idx == tail_idx);
	assign empty = (head_q == tail_q);

	// combine free list and map table results
	assign rsp_o.src1_tag     = src1_tag_i;
	assign rsp_o.src2_tag     = src2_tag_i;
	assign rsp_o.dest_tag     = new_tag_i;
	assign rsp_o.old_dest_tag = old_tag_i;

	// entry captured at the tail
	assign new_entry.logic_dest   = req_i.logic_dest;
	assign new_entry.dest_tag     = new_tag_i;
	assign new_entry.old_dest_tag = old_tag_i;

	assign head_entry = entry_q[head_idx];

	assign dispatch_rdy_o = !full;
	assign retire_rdy_o   = !empty && done_q[head_idx]; // younger done entries wait

	// head entry goes out as is
	assign retire_o.logic_dest   = head_entry.logic_dest;
	assign retire_o.dest_tag     = head_entry.dest_tag;
	assign retire_o.old_dest_tag = head_entry.old_dest_tag;

	assign free_o     = retire_i;                // one tag per retirement
	assign free_tag_o = head_entry.old_dest_tag; // displaced tag of the retiring head

	// pointers
	always_ff @(posedge clock) begin
		if (reset) begin
			head_q <= '0;
			tail_q <= '0;
		end else begin
			if (dispatch_i) tail_q <= tail_q + 1'b1;
			if (retire_i)   head_q <= head_q + 1'b1;
		end
	end

	// occupancy and completion flags
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= '0;
			done_q  <= '0;
		end else begin
			// tags in flight are unique, at most one slot matches
			if (ex_done_i) begin
				for (int i = 0; i < rename_pkg::ROB_DEPTH; i++) begin
					if (valid_q[i] && entry_q[i].dest_tag == ex_tag_i) begin
						done_q[i] <= 1'b1;
					end
				end
			end
			if (dispatch_i) begin
				valid_q[tail_idx] <= 1'b1;
				done_q[tail_idx]  <= 1'b0; // fresh entry starts pending
			end
			if (retire_i) begin
				valid_q[head_idx] <= 1'b0; // slot free again
			end
		end
	end

	// payload
	always_ff @(posedge clock) begin
		if (dispatch_i) begin
			entry_q[tail_idx] <= new_entry;
		end
	end

endmodule

// File: logic/rename_top.sv
// register rename and retire core

`timescale 1ns/10ps

module rename_top (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         dispatch_i,
	input  rename_pkg::rename_req_t      req_i,
	input  logic                         ex_done_i,
	input  logic [rename_pkg::TAG_W-1:0] ex_tag_i,
	input  logic                         retire_i,
	output rename_pkg::rename_rsp_t      rsp_o,
	output logic                         dispatch_rdy_o,
	output logic                         retire_rdy_o,
	output rename_pkg::retire_info_t     retire_o
);

	logic [rename_pkg::TAG_W-1:0] free_tag; // head of the free list
	logic [rename_pkg::TAG_W-1:0] src1_tag;
	logic [rename_pkg::TAG_W-1:0] src2_tag;
	logic [rename_pkg::TAG_W-1:0] old_tag;  // displaced mapping
	logic                         free;     // retirement returns a tag
	logic [rename_pkg::TAG_W-1:0] ret_tag;

	// tag supply
	free_list u_free_list (
		.clock      (clock),
		.reset      (reset),
		.dispatch_i (dispatch_i),
		.push_i     (free),
		.push_tag_i (ret_tag),
		.free_tag_o (free_tag)
	);

	// source and destination translation
	map_table u_map_table (
		.clock      (clock),
		.reset      (reset),
		.dispatch_i (dispatch_i),
		.req_i      (req_i),
		.new_tag_i  (free_tag),
		.src1_tag_o (src1_tag),
		.src2_tag_o (src2_tag),
		.old_tag_o  (old_tag)
	);

	// ordering, completion and retirement
	rob u_rob (
		.clock          (clock),
		.reset          (reset),
		.dispatch_i     (dispatch_i),
		.req_i          (req_i),
		.new_tag_i      (free_tag),
		.src1_tag_i     (src1_tag),
		.src2_tag_i     (src2_tag),
		.old_tag_i      (old_tag),
		.ex_done_i      (ex_done_i),
		.ex_tag_i       (ex_tag_i),
		.retire_i       (retire_i),
		.rsp_o          (rsp_o),
		.dispatch_rdy_o (dispatch_rdy_o),
		.retire_rdy_o   (retire_rdy_o),
		.retire_o       (retire_o),
		.free_o         (free),
		.free_tag_o     (ret_tag)
	);

endmodule

// File: verification/rename_tb.sv
// rename core testbench

`timescale 1ns/10ps

module rename_tb;

	// model view of one instruction in flight
	typedef struct packed {
		logic [rename_pkg::LOGIC_W-1:0] logic_dest;
		logic [rename_pkg::TAG_W-1:0]   dest_tag;
		logic [rename_pkg::TAG_W-1:0]   old_dest_tag;
		logic                           done;
	} inflight_t;

	logic                         clock;
	logic                         reset;
	logic                         dispatch_i;
	rename_pkg::rename_req_t      req_i;
	logic                         ex_done_i;
	logic [rename_pkg::TAG_W-1:0] ex_tag_i;
	logic                         retire_i;
	rename_pkg::rename_rsp_t      rsp_o;
	logic                         dispatch_rdy_o;
	logic                         retire_rdy_o;
	rename_pkg::retire_info_t     retire_o;

	// reference model, always one edge ahead of the dut between steps
	logic [rename_pkg::TAG_W-1:0] map_m [rename_pkg::NUM_LOGIC];
	logic [rename_pkg::TAG_W-1:0] free_q [$];       // oldest free tag first
	inflight_t                    inflight [$];     // dispatch order
	logic [rename_pkg::TAG_W-1:0] retired_olds [$]; // every freed tag in order
	int                           disp_count;       // dispatches since reset
	logic [31:0]                  lfsr_q;

	rename_top uut (
		.clock          (clock),
		.reset          (reset),
		.dispatch_i     (dispatch_i),
		.req_i          (req_i),
		.ex_done_i      (ex_done_i),
		.ex_tag_i       (ex_tag_i),
		.retire_i       (retire_i),
		.rsp_o          (rsp_o),
		.dispatch_rdy_o (dispatch_rdy_o),
		.retire_rdy_o   (retire_rdy_o),
		.retire_o       (retire_o)
	);

	// 40 ns period
	always begin
		clock = 1'b0;
		#20;
		clock = 1'b1;
		#20;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// one lfsr step per bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			r = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	function automatic rename_pkg::rename_req_t make_req(input int dest, input int s1, input int s2);
		rename_pkg::rename_req_t q;
		q.logic_dest = dest[rename_pkg::LOGIC_W-1:0];
		q.src1       = s1[rename_pkg::LOGIC_W-1:0];
		q.src2       = s2[rename_pkg::LOGIC_W-1:0];
		return q;
	endfunction

	function automatic rename_pkg::rename_req_t rand_req();
		logic [31:0] r;
		r = rand_bits(15);
		return r[14:0]; // dest, src1, src2
	endfunction

	task automatic abort_run(input string why);
		$display("*** FAILED ***");
		$fatal(1, "%s", why);
	endtask

	task automatic expect_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act == exp) else begin
			$display("Error: %s expected 0x%0h, got 0x%0h", name, exp, act);
			abort_run("value mismatch");
		end
	endtask

	// drive one cycle, check the dut at the falling edge, then move the model
	task automatic step(input logic disp, input rename_pkg::rename_req_t req, input logic done,
		input logic [rename_pkg::TAG_W-1:0] tag, input logic ret);
		inflight_t e;
		logic      rdy;
		@(posedge clock);
		dispatch_i <= disp;
		req_i      <= req;
		ex_done_i  <= done;
		ex_tag_i   <= tag;
		retire_i   <= ret;
		@(negedge clock);
		rdy = (inflight.size() > 0) && inflight[0].done;
		expect_equal("dispatch_rdy_o", inflight.size() < rename_pkg::ROB_DEPTH, dispatch_rdy_o);
		expect_equal("retire_rdy_o", rdy, retire_rdy_o);
		assert (!disp || inflight.size() < rename_pkg::ROB_DEPTH) else
			abort_run("dispatch issued while the reorder buffer is full");
		assert (!ret || rdy) else
			abort_run("retire issued while the head entry is not done");
		if (inflight.size() < rename_pkg::ROB_DEPTH) begin
			expect_equal("rsp_o.src1_tag", map_m[req.src1], rsp_o.src1_tag);
			expect_equal("rsp_o.src2_tag", map_m[req.src2], rsp_o.src2_tag);
			expect_equal("rsp_o.dest_tag", free_q[0], rsp_o.dest_tag);
			expect_equal("rsp_o.old_dest_tag", map_m[req.logic_dest], rsp_o.old_dest_tag);
		end
		if (ret) begin
			expect_equal("retire_o.logic_dest", inflight[0].logic_dest, retire_o.logic_dest);
			expect_equal("retire_o.dest_tag", inflight[0].dest_tag, retire_o.dest_tag);
			expect_equal("retire_o.old_dest_tag", inflight[0].old_dest_tag, retire_o.old_dest_tag);
		end
		// what the coming edge does
		if (done) begin
			for (int i = 0; i < inflight.size(); i++) begin
				if (inflight[i].dest_tag == tag) begin
					e = inflight[i];
					e.done = 1'b1;
					inflight[i] = e;
				end
			end
		end
		if (disp) begin
			e.logic_dest   = req.logic_dest;
			e.dest_tag     = free_q.pop_front();
			e.old_dest_tag = map_m[req.logic_dest]; // mapping before this write
			e.done         = 1'b0;
			map_m[req.logic_dest] = e.dest_tag;
			inflight.push_back(e);
			disp_count++;
		end
		if (ret) begin
			e = inflight.pop_front();
			free_q.push_back(e.old_dest_tag); // back of the line
			retired_olds.push_back(e.old_dest_tag);
		end
	endtask

	task automatic step_idle();
		step(1'b0, '0, 1'b0, '0, 1'b0);
	endtask

	// after an idle step the dut has caught up with the model
	task automatic wait_retire_ready(input int limit);
		int n;
		n = 0;
		step_idle();
		while (!retire_rdy_o) begin
			if (n >= limit) begin
				$display("timeout, retire_rdy_o stayed low for %0d cycles", limit);
				abort_run("retire ready never rose");
			end
			step_idle();
			n++;
		end
	endtask

	// complete oldest pending entries and retire until the model is empty
	task automatic drain();
		int                           guard;
		int                           k;
		logic [rename_pkg::TAG_W-1:0] tag;
		guard = 0;
		while (inflight.size() > 0) begin
			k = -1;
			tag = '0;
			for (int i = inflight.size() - 1; i >= 0; i--) begin
				if (!inflight[i].done) k = i;
			end
			if (k >= 0) tag = inflight[k].dest_tag;
			step(1'b0, '0, k >= 0, tag, inflight[0].done);
			guard++;
			if (guard > 200) begin
				$display("timeout, reorder buffer did not drain in %0d cycles", guard);
				abort_run("drain stuck");
			end
		end
	endtask

	task automatic reset_state_check();
		step_idle();
		expect_equal("dispatch_rdy_o", 1, dispatch_rdy_o);
		expect_equal("retire_rdy_o", 0, retire_rdy_o);
		expect_equal("rsp_o.dest_tag", 32, rsp_o.dest_tag); // first free tag
		step(1'b0, make_req(3, 7, 19), 1'b0, '0, 1'b0);
		expect_equal("rsp_o.src1_tag", 7, rsp_o.src1_tag); // identity map
		expect_equal("rsp_o.src2_tag", 19, rsp_o.src2_tag);
		expect_equal("rsp_o.old_dest_tag", 3, rsp_o.old_dest_tag);
	endtask

	task automatic rename_chain();
		logic [31:0] prev;
		prev = 5;
		for (int i = 0; i < 4; i++) begin
			step(1'b1, make_req(5, 5, 9), 1'b0, '0, 1'b0);
			expect_equal("rsp_o.dest_tag", 32 + i, rsp_o.dest_tag);
			expect_equal("rsp_o.old_dest_tag", prev, rsp_o.old_dest_tag);
			expect_equal("rsp_o.src1_tag", prev, rsp_o.src1_tag); // pre-dispatch view
			expect_equal("rsp_o.src2_tag", 9, rsp_o.src2_tag);
			prev = 32 + i;
		end
		step(1'b1, make_req(6, 5, 5), 1'b0, '0, 1'b0);
		expect_equal("rsp_o.src1_tag", 35, rsp_o.src1_tag); // newest r5
		expect_equal("rsp_o.dest_tag", 36, rsp_o.dest_tag);
		drain();
	endtask

	task automatic in_order_retire();
		logic [rename_pkg::TAG_W-1:0] order [$];
		for (int i = 0; i < 6; i++) begin
			step(1'b1, rand_req(), 1'b0, '0, 1'b0);
			order.push_back(inflight[inflight.size()-1].dest_tag);
		end
		// youngest first, head stays pending until the last one
		for (int k = 5; k >= 0; k--) begin
			step(1'b0, '0, 1'b1, order[k], 1'b0);
			expect_equal("retire_rdy_o", 0, retire_rdy_o);
		end
		for (int i = 0; i < 6; i++) begin
			wait_retire_ready(4);
			expect_equal("retire_o.dest_tag", order[i], retire_o.dest_tag);
			step(1'b0, '0, 1'b0, '0, 1'b1);
		end
	endtask

	task automatic fill_rob();
		for (int i = 0; i < rename_pkg::ROB_DEPTH; i++) begin
			step(1'b1, rand_req(), 1'b0, '0, 1'b0);
		end
		step_idle();
		expect_equal("dispatch_rdy_o", 0, dispatch_rdy_o);
		step(1'b0, '0, 1'b1, inflight[0].dest_tag, 1'b0);
		wait_retire_ready(4);
		step(1'b0, '0, 1'b0, '0, 1'b1);
		expect_equal("dispatch_rdy_o", 0, dispatch_rdy_o); // retire edge not yet seen
		step_idle();
		expect_equal("dispatch_rdy_o", 1, dispatch_rdy_o);
		drain();
	endtask

	// tags 32..63 first, then freed tags in the order they were freed
	task automatic tag_recycling();
		logic [31:0] exp;
		for (int i = 0; i < 12; i++) begin
			exp = (disp_count < 32) ? 32 + disp_count : retired_olds[disp_count - 32];
			step(1'b1, rand_req(), 1'b0, '0, 1'b0);
			expect_equal("rsp_o.dest_tag", exp, rsp_o.dest_tag);
		end
		drain();
	endtask

	task automatic random_mix();
		int                           pending [$];
		logic [31:0]                  r;
		logic                         disp;
		logic                         done;
		logic                         ret;
		logic [rename_pkg::TAG_W-1:0] tag;
		for (int c = 0; c < 400; c++) begin
			pending.delete();
			for (int i = 0; i < inflight.size(); i++) begin
				if (!inflight[i].done) pending.push_back(i);
			end
			r = rand_bits(2);
			disp = (inflight.size() < rename_pkg::ROB_DEPTH) && (r != 0); // three in four
			r = rand_bits(1);
			done = (pending.size() > 0) && r[0];
			tag = '0;
			if (done) begin
				r = rand_bits(5);
				tag = inflight[pending[r % pending.size()]].dest_tag;
			end
			ret = (inflight.size() > 0) && inflight[0].done; // retire as soon as ready
			step(disp, rand_req(), done, tag, ret);
		end
		drain();
	endtask

	initial begin
		lfsr_q     = 32'hbeaf;
		disp_count = 0;
		for (int r = 0; r < rename_pkg::NUM_LOGIC; r++) begin
			map_m[r] = r[rename_pkg::TAG_W-1:0];
		end
		for (int i = 32; i < rename_pkg::NUM_TAGS; i++) begin
			free_q.push_back(i[rename_pkg::TAG_W-1:0]);
		end
		reset      = 1'b1;
		dispatch_i = 1'b0;
		req_i      = '0;
		ex_done_i  = 1'b0;
		ex_tag_i   = '0;
		retire_i   = 1'b0;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		reset_state_check();
		rename_chain();
		in_order_retire();
		fill_rob();
		tag_recycling();
		random_mix();
		step_idle();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: tb.f
logic/rename_pkg.sv
logic/free_list.sv
logic/map_table.sv
logic/rob.sv
logic/rename_top.sv
verification/rename_tb.sv

// File: Bender.yml
# register rename and in-order retirement core

package:
  name: rename_core

dependencies: {}

sources:
  # design, package first
  - files:
      - logic/rename_pkg.sv
      - logic/free_list.sv
      - logic/map_table.sv
      - logic/rob.sv
      - logic/rename_top.sv

  # testbench, top module rename_tb
  - target: simulation
    files:
      - verification/rename_tb.sv
